/* files.f */
+incdir+verilog
verilog/n64adv_pkg.sv
verilog/n64adv_cfgRegs.sv
verilog/n64adv_vDemux.sv
verilog/n64adv_vOutput.sv
verilog/n64adv_top.sv
verif/n64adv_chk.sv
verif/n64adv_tb.sv

/* verif/n64adv_tb.sv */
// Drives frames and Wishbone accesses into the video path top and checks every DAC pixel
`timescale 1ns/1ps
`default_nettype none

`include "n64adv_defs.svh"

module n64adv_tb
  import n64adv_pkg::*;
;

  // Short frames exercise the settings and long frames the line count
  localparam int SmallLines = 6;
  localparam int SmallPix   = 4;
  localparam int BigLines   = 300;
  localparam int BigPix     = 3;
  localparam int HsPix      = 1;
  localparam int VsLines    = 1;
  localparam int RstCycles  = 10;
  // Seven short frames, two long ones, plus idle and bus slack
  localparam int StimCycles = RstCycles + 7 * SmallLines * SmallPix * 4
                              + 2 * BigLines * BigPix * 4 + 200;
  localparam int CycleLimit = 2 * StimCycles;

  logic      VCLK = 1'b0;
  logic      rstN;
  logic      nVDSync;
  colorIn_t  vd;
  logic      wbCyc;
  logic      wbStb;
  logic      wbWe;
  logic      wbAdr;
  wbData_t   wbDatW;
  wire       wbData_t wbDatR;
  wire       wbAck;
  logic      useVgaJmp;
  logic      nRGsBJmp;
  slStr_t    slJmpN;
  wire       pixStrobe;
  wire       colorOut_t vdR;
  wire       colorOut_t vdG;
  wire       colorOut_t vdB;
  wire       nCSync;
  wire       nHSync;
  wire       nVSync;

  integer    seed;
  int        cycCnt = 0;
  int        pixCnt = 0;
  int        valErr = 0;
  int        timeErr = 0;
  int        otherErr = 0;

  // Expected pixels {R, G, B, nCSync, nHSync, nVSync} and the cycle they are due
  logic [26:0] expQ[$];
  int          expCycQ[$];
  logic [26:0] cmpExp;
  int          cmpCyc;

  // Reference model of line tracking and configuration
  logic      hsPrevM;
  logic      vsPrevM;
  logic      oddM;
  int        lineCntM;
  int        lastCntM;
  logic [4:0] cfgM;

  n64adv_top uut (
    .VCLK              (VCLK),
    .rstN_i            (rstN),
    .nVDSYNC_i         (nVDSync),
    .vd_i              (vd),
    .wbCyc_i           (wbCyc),
    .wbStb_i           (wbStb),
    .wbWe_i            (wbWe),
    .wbAdr_i           (wbAdr),
    .wbDat_i           (wbDatW),
    .wbDat_o           (wbDatR),
    .wbAck_o           (wbAck),
    .useVgaHVSyncJmp_i (useVgaJmp),
    .nEnRGsBJmp_i      (nRGsBJmp),
    .slStrJmpN_i       (slJmpN),
    .pixStrobe_o       (pixStrobe),
    .vdR_o             (vdR),
    .vdG_o             (vdG),
    .vdB_o             (vdB),
    .nCSync_o          (nCSync),
    .nHSyncOrF1_o      (nHSync),
    .nVSyncOrF2_o      (nVSync)
  );

  always #4 VCLK = ~VCLK;

  always @(posedge VCLK) begin
    cycCnt <= cycCnt + 1;
  end

  ////////////////////
  // Reference
  ////////////////////

  // Expected DAC pixel from the console words, line parity and settings
  function automatic logic [26:0] expectPixel(input colorIn_t r, input colorIn_t g,
      input colorIn_t b, input syncBits_t sync, input logic odd, input logic vga,
      input logic rgsb, input slStr_t sl);
    int         c[3];
    colorIn_t   in[3];
    logic [7:0] out[3];
    in[0] = r;
    in[1] = g;
    in[2] = b;
    for (int i = 0; i < 3; i++) begin
      // Widen by repeating the top bit below the word
      c[i] = int'(in[i]) * 2 + int'(in[i][`COLOR_W_I-1]);
      // Odd lines lose a quarter step per strength level
      if (odd) begin
        c[i] = c[i] - (c[i] * int'(sl)) / 4;
      end
      out[i] = 8'(c[i]);
    end
    if (rgsb && !sync[`SYNC_CS]) begin
      out[1] = 8'h00;
    end
    return {out[0], out[1], out[2], sync[`SYNC_CS],
            vga ? sync[`SYNC_HS] : 1'b1, vga ? sync[`SYNC_VS] : 1'b1};
  endfunction

  // Hsync low on the first pixels of a line and vsync low on the first lines of a frame
  function automatic syncBits_t makeSync(input int line, input int pix);
    syncBits_t s;
    s = '1;
    if (pix < HsPix) s[`SYNC_HS] = 1'b0;
    if (line < VsLines) s[`SYNC_VS] = 1'b0;
    s[`SYNC_CS] = s[`SYNC_HS] & s[`SYNC_VS];
    if (pix == HsPix) s[`SYNC_CLAMP] = 1'b0;
    return s;
  endfunction

  // Advance the line model by one pixel and queue what the DAC should show
  task automatic modelPixel(input colorIn_t r, input colorIn_t g, input colorIn_t b,
      input syncBits_t sync, input int blueCyc);
    logic   vga;
    logic   rgsb;
    slStr_t sl;
    if (vsPrevM && !sync[`SYNC_VS]) begin
      lastCntM = lineCntM;
      lineCntM = 0;
      oddM = 1'b0;
    end else if (hsPrevM && !sync[`SYNC_HS]) begin
      lineCntM++;
      oddM = ~oddM;
    end
    hsPrevM = sync[`SYNC_HS];
    vsPrevM = sync[`SYNC_VS];
    // Override bit picks the register over the jumpers
    if (cfgM[0]) begin
      vga = cfgM[1];
      rgsb = cfgM[2];
      sl = cfgM[4:3];
    end else begin
      vga = useVgaJmp;
      rgsb = ~nRGsBJmp;
      sl = ~slJmpN;
    end
    expQ.push_back(expectPixel(r, g, b, sync, oddM, vga, rgsb, sl));
    expCycQ.push_back(blueCyc + 2);
  endtask

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      valErr++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // Sync word followed by red, green and blue on the next falling edges
  task automatic sendGroup(input syncBits_t sync);
    colorIn_t r;
    colorIn_t g;
    colorIn_t b;
    r = colorIn_t'($random(seed));
    g = colorIn_t'($random(seed));
    b = colorIn_t'($random(seed));
    @(negedge VCLK);
    nVDSync = 1'b0;
    vd = {3'b000, sync};
    @(negedge VCLK);
    nVDSync = 1'b1;
    vd = r;
    @(negedge VCLK);
    vd = g;
    @(negedge VCLK);
    vd = b;
    modelPixel(r, g, b, sync, cycCnt);
  endtask

  // Group cut short by a new sync word after some colour words
  task automatic abortGroup(input int words);
    @(negedge VCLK);
    nVDSync = 1'b0;
    vd = 7'h0f;
    repeat (words) begin
      @(negedge VCLK);
      nVDSync = 1'b1;
      vd = colorIn_t'($random(seed));
    end
  endtask

  task automatic sendFrame(input int lines, input int pix);
    for (int l = 0; l < lines; l++) begin
      for (int p = 0; p < pix; p++) begin
        sendGroup(makeSync(l, p));
      end
    end
  endtask

  // Bus quiet long enough to flush the pixel pipeline
  task automatic idle(input int n);
    repeat (n) begin
      @(negedge VCLK);
      nVDSync = 1'b1;
      vd = colorIn_t'($random(seed));
    end
  endtask

  task automatic setJumpers(input logic vga, input logic nRGsB, input slStr_t slN);
    idle(4);
    useVgaJmp = vga;
    nRGsBJmp = nRGsB;
    slJmpN = slN;
  endtask

  // One classic cycle with read data and latency checked on the ack
  task automatic wbAccess(input logic we, input logic adr, input wbData_t data,
      input wbData_t expRd);
    int waitCyc;
    @(negedge VCLK);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = we;
    wbAdr = adr;
    wbDatW = data;
    waitCyc = 0;
    do begin
      @(negedge VCLK);
      waitCyc++;
    end while (!wbAck);
    assert (waitCyc == 1) else begin
      otherErr++;
      $display("Wishbone ack came %0d cycles after the request instead of 1", waitCyc);
    end
    if (!we) checkValue("wbDat_o", wbDatR, expRd);
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    // Status address ignores writes
    if (we && adr == 1'(`ADDR_CFG)) cfgM = data[4:0];
  endtask

  task automatic reportCounts();
    $display("Checked %0d pixels: %0d value errors, %0d timing errors, %0d other errors",
             pixCnt, valErr, timeErr, otherErr);
  endtask

  ////////////////////
  // Compare
  ////////////////////

  always @(negedge VCLK) begin
    if (rstN && pixStrobe) begin
      assert (expQ.size() != 0) else begin
        otherErr++;
        $display("Pixel strobe at cycle %0d with no pixel expected", cycCnt);
      end
      if (expQ.size() != 0) begin
        cmpExp = expQ.pop_front();
        cmpCyc = expCycQ.pop_front();
        pixCnt++;
        assert (cycCnt == cmpCyc) else begin
          timeErr++;
          $display("Pixel appeared at cycle %0d instead of cycle %0d", cycCnt, cmpCyc);
        end
        checkValue("vdR_o", vdR, cmpExp[26:19]);
        checkValue("vdG_o", vdG, cmpExp[18:11]);
        checkValue("vdB_o", vdB, cmpExp[10:3]);
        checkValue("nCSync_o", 8'(nCSync), 8'(cmpExp[2]));
        checkValue("nHSyncOrF1_o", 8'(nHSync), 8'(cmpExp[1]));
        checkValue("nVSyncOrF2_o", 8'(nVSync), 8'(cmpExp[0]));
      end
    end
  end

  // Watchdog on the cycle counter
  initial begin
    while (cycCnt < CycleLimit) @(posedge VCLK);
    $display("Timeout: run still going after %0d cycles", CycleLimit);
    reportCounts();
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    seed = 66;
    rstN = 1'b0;
    nVDSync = 1'b1;
    vd = '0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = 1'b0;
    wbDatW = '0;
    // Jumpers start without scanlines or RGsB and with H/V syncs on
    useVgaJmp = 1'b1;
    nRGsBJmp = 1'b1;
    slJmpN = 2'b11;
    hsPrevM = 1'b1;
    vsPrevM = 1'b1;
    oddM = 1'b0;
    lineCntM = 0;
    lastCntM = 0;
    cfgM = '0;
    repeat (RstCycles) @(negedge VCLK);
    checkValue("pixStrobe_o", 8'(pixStrobe), 8'h00);
    checkValue("wbAck_o", 8'(wbAck), 8'h00);
    checkValue("vdR_o", vdR, 8'h00);
    checkValue("vdG_o", vdG, 8'h00);
    checkValue("vdB_o", vdB, 8'h00);
    checkValue("nCSync_o", 8'(nCSync), 8'h01);
    checkValue("nHSyncOrF1_o", 8'(nHSync), 8'h01);
    checkValue("nVSyncOrF2_o", 8'(nVSync), 8'h01);
    rstN = 1'b1;
    // Plain widening and sync pass-through
    sendFrame(SmallLines, SmallPix);
    // Every scanline strength from the jumpers
    for (int s = 1; s < 4; s++) begin
      setJumpers(1'b1, 1'b1, slStr_t'(~s));
      sendFrame(SmallLines, SmallPix);
    end
    // RGsB first and then H/V syncs switched off
    setJumpers(1'b1, 1'b0, 2'b11);
    sendFrame(SmallLines, SmallPix);
    setJumpers(1'b0, 1'b1, 2'b11);
    sendFrame(SmallLines, SmallPix);
    // Register override against opposite jumpers
    setJumpers(1'b0, 1'b0, 2'b11);
    wbAccess(1'b1, 1'(`ADDR_CFG), 8'h13, 8'h00);
    wbAccess(1'b0, 1'(`ADDR_CFG), 8'h00, 8'h13);
    wbAccess(1'b1, 1'(`ADDR_STAT), 8'hff, 8'h00);
    wbAccess(1'b0, 1'(`ADDR_CFG), 8'h00, 8'h13);
    sendFrame(SmallLines, SmallPix);
    // Line count over two long frames
    sendFrame(BigLines, BigPix);
    sendFrame(BigLines, BigPix);
    idle(4);
    wbAccess(1'b0, 1'(`ADDR_STAT), 8'h00, 8'(lastCntM));
    // Groups cut after red and after green give no pixel
    abortGroup(1);
    abortGroup(2);
    sendGroup(4'hf);
    idle(4);
    for (int i = 0; i < 16 && expQ.size() != 0; i++) @(negedge VCLK);
    assert (expQ.size() == 0) else begin
      otherErr++;
      $display("%0d expected pixels never reached the DAC outputs", expQ.size());
    end
    reportCounts();
    if (valErr + timeErr + otherErr == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/n64adv_chk.sv */
// Concurrent checks on the Wishbone handshake and the pixel strobe, bound into the video path top
`timescale 1ns/1ps
`default_nettype none

module n64adv_chk (
  input wire VCLK,
  input wire rstN_i,
  input wire wbCyc_i,
  input wire wbStb_i,
  input wire wbAck_i,
  input wire pixStrobe_i
);

  ////////////////////
  // Wishbone slave
  ////////////////////

  // Ack is a single-cycle pulse
  ackPulse: assert property (@(posedge VCLK) disable iff (!rstN_i) wbAck_i |=> !wbAck_i)
    else $error("Wishbone ack held high for two cycles in a row");

  // Ack only answers a request seen on the previous edge
  ackAfterReq: assert property (@(posedge VCLK) disable iff (!rstN_i)
    wbAck_i |-> $past(wbCyc_i && wbStb_i))
    else $error("Wishbone ack without a preceding cyc and stb");

  ////////////////////
  // Pixel output
  ////////////////////

  // At most one pixel per four-cycle group
  strobePulse: assert property (@(posedge VCLK) disable iff (!rstN_i)
    pixStrobe_i |=> !pixStrobe_i)
    else $error("Pixel strobe high on two consecutive cycles");

endmodule

bind n64adv_top n64adv_chk chkU (
  .VCLK        (VCLK),
  .rstN_i      (rstN_i),
  .wbCyc_i     (wbCyc_i),
  .wbStb_i     (wbStb_i),
  .wbAck_i     (wbAck_o),
  .pixStrobe_i (pixStrobe_o)
);

`default_nettype wire

/* verilog/n64adv_top.sv */
// Top of the single-clock video path, joins register block, demux and output stage to the pins
`timescale 1ns/1ps
`default_nettype none

module n64adv_top
  import n64adv_pkg::*;
(
  // Console video input
  input  wire           VCLK,
  input  wire           rstN_i,
  input  wire           nVDSYNC_i,
  input  wire colorIn_t vd_i,

  // Wishbone classic slave
  input  wire           wbCyc_i,
  input  wire           wbStb_i,
  input  wire           wbWe_i,
  input  wire           wbAdr_i,
  input  wire wbData_t  wbDat_i,
  output wire wbData_t  wbDat_o,
  output wire           wbAck_o,

  // Jumpers
  input  wire           useVgaHVSyncJmp_i,
  input  wire           nEnRGsBJmp_i,
  input  wire slStr_t   slStrJmpN_i,

  // DAC data and syncs
  output wire            pixStrobe_o,
  output wire colorOut_t vdR_o,
  output wire colorOut_t vdG_o,
  output wire colorOut_t vdB_o,
  output wire            nCSync_o,
  output wire            nHSyncOrF1_o,
  output wire            nVSyncOrF2_o
);

  // Demux to output stage
  wire            pixValid;
  wire colorIn_t  pixRed;
  wire colorIn_t  pixGreen;
  wire colorIn_t  pixBlue;
  wire syncBits_t pixSync;

  // Settings and status between register block and output stage
  wire            useVgaSync;
  wire            enRGsB;
  wire slStr_t    slStr;
  wire lineCnt_t  lastLineCnt;

  ////////////////////
  // Controller side
  ////////////////////

  n64adv_cfgRegs cfgRegsU (
    .VCLK              (VCLK),
    .rstN_i            (rstN_i),
    .wbCyc_i           (wbCyc_i),
    .wbStb_i           (wbStb_i),
    .wbWe_i            (wbWe_i),
    .wbAdr_i           (wbAdr_i),
    .wbDat_i           (wbDat_i),
    .wbDat_o           (wbDat_o),
    .wbAck_o           (wbAck_o),
    .useVgaHVSyncJmp_i (useVgaHVSyncJmp_i),
    .nEnRGsBJmp_i      (nEnRGsBJmp_i),
    .slStrJmpN_i       (slStrJmpN_i),
    .lastLineCnt_i     (lastLineCnt),
    .useVgaSync_o      (useVgaSync),
    .enRGsB_o          (enRGsB),
    .slStr_o           (slStr)
  );

  ////////////////////
  // Picture path
  ////////////////////

  n64adv_vDemux vDemuxU (
    .VCLK       (VCLK),
    .rstN_i     (rstN_i),
    .nVDSYNC_i  (nVDSYNC_i),
    .vd_i       (vd_i),
    .pixValid_o (pixValid),
    .red_o      (pixRed),
    .green_o    (pixGreen),
    .blue_o     (pixBlue),
    .pixSync_o  (pixSync)
  );

  n64adv_vOutput vOutputU (
    .VCLK          (VCLK),
    .rstN_i        (rstN_i),
    .pixValid_i    (pixValid),
    .red_i         (pixRed),
    .green_i       (pixGreen),
    .blue_i        (pixBlue),
    .pixSync_i     (pixSync),
    .useVgaSync_i  (useVgaSync),
    .enRGsB_i      (enRGsB),
    .slStr_i       (slStr),
    .pixStrobe_o   (pixStrobe_o),
    .vdR_o         (vdR_o),
    .vdG_o         (vdG_o),
    .vdB_o         (vdB_o),
    .nCSync_o      (nCSync_o),
    .nHSyncOrF1_o  (nHSyncOrF1_o),
    .nVSyncOrF2_o  (nVSyncOrF2_o),
    .lastLineCnt_o (lastLineCnt)
  );

endmodule

`default_nettype wire

/* verilog/n64adv_vOutput.sv */
// Output stage that widens colours, applies scanlines and RGsB and registers DAC data and syncs
`timescale 1ns/1ps
`default_nettype none

`include "n64adv_defs.svh"

module n64adv_vOutput
  import n64adv_pkg::*;
(
  input  wire            VCLK,
  input  wire            rstN_i,

  // Pixel from the demux
  input  wire            pixValid_i,
  input  wire colorIn_t  red_i,
  input  wire colorIn_t  green_i,
  input  wire colorIn_t  blue_i,
  input  wire syncBits_t pixSync_i,

  // Effective settings
  input  wire            useVgaSync_i,
  input  wire            enRGsB_i,
  input  wire slStr_t    slStr_i,

  // DAC side
  output logic           pixStrobe_o,
  output colorOut_t      vdR_o,
  output colorOut_t      vdG_o,
  output colorOut_t      vdB_o,
  output logic           nCSync_o,
  output logic           nHSyncOrF1_o,
  output logic           nVSyncOrF2_o,

  // Lines of the last complete frame
  output lineCnt_t       lastLineCnt_o
);

  // Append own MSB to reach DAC width
  function automatic colorOut_t widen(input colorIn_t c);
    return {c, c[`COLOR_W_I-1]};
  endfunction

  // Subtract floor(c * s / 4)
  function automatic colorOut_t dim(input colorOut_t c, input slStr_t s);
    logic [`COLOR_W_O+1:0] prod;
    prod = c * s;
    return c - prod[`COLOR_W_O+1:2];
  endfunction

  logic      hsPrev;
  logic      vsPrev;
  logic      hsFall;
  logic      vsFall;
  logic      lineOdd;
  logic      lineOddNow;
  lineCnt_t  lineCnt;
  colorOut_t rNew;
  colorOut_t gNew;
  colorOut_t bNew;

  ////////////////////
  // Line tracking
  ////////////////////

  // Edges seen between consecutive pixels
  assign hsFall = hsPrev & ~pixSync_i[`SYNC_HS];
  assign vsFall = vsPrev & ~pixSync_i[`SYNC_VS];

  // Parity of the line this pixel belongs to
  always_comb begin
    if (vsFall) begin
      lineOddNow = 1'b0;
    end else if (hsFall) begin
      lineOddNow = ~lineOdd;
    end else begin
      lineOddNow = lineOdd;
    end
  end

  ////////////////////
  // Pixel processing
  ////////////////////

  always_comb begin
    rNew = widen(red_i);
    gNew = widen(green_i);
    bNew = widen(blue_i);
    // Scanlines on odd lines only
    if (lineOddNow) begin
      rNew = dim(rNew, slStr_i);
      gNew = dim(gNew, slStr_i);
      bNew = dim(bNew, slStr_i);
    end
    // Green carries no video during csync for RGsB
    if (enRGsB_i && !pixSync_i[`SYNC_CS]) begin
      gNew = '0;
    end
  end

  always_ff @(posedge VCLK or negedge rstN_i) begin
    if (!rstN_i) begin
      pixStrobe_o   <= 1'b0;
      hsPrev        <= 1'b1;
      vsPrev        <= 1'b1;
      lineOdd       <= 1'b0;
      lineCnt       <= '0;
      lastLineCnt_o <= '0;
      vdR_o         <= '0;
      vdG_o         <= '0;
      vdB_o         <= '0;
      nCSync_o      <= 1'b1;
      nHSyncOrF1_o  <= 1'b1;
      nVSyncOrF2_o  <= 1'b1;
    end else begin
      pixStrobe_o <= pixValid_i;
      if (pixValid_i) begin
        hsPrev  <= pixSync_i[`SYNC_HS];
        vsPrev  <= pixSync_i[`SYNC_VS];
        lineOdd <= lineOddNow;
        // Frame start stores the count, then restarts it
        if (vsFall) begin
          lastLineCnt_o <= lineCnt;
          lineCnt       <= '0;
        end else if (hsFall) begin
          lineCnt <= lineCnt + 1'b1;
        end
        vdR_o <= rNew;
        vdG_o <= gNew;
        vdB_o <= bNew;
        nCSync_o <= pixSync_i[`SYNC_CS];
        // H/V syncs only with the VGA sync setting
        nHSyncOrF1_o <= useVgaSync_i ? pixSync_i[`SYNC_HS] : 1'b1;
        nVSyncOrF2_o <= useVgaSync_i ? pixSync_i[`SYNC_VS] : 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/n64adv_vDemux.sv */
// Demultiplexes the four-phase console video bus into one registered pixel per group
`timescale 1ns/1ps
`default_nettype none

`include "n64adv_defs.svh"

module n64adv_vDemux
  import n64adv_pkg::*;
(
  input  wire           VCLK,
  input  wire           rstN_i,

  // Console video bus
  input  wire           nVDSYNC_i,
  input  wire colorIn_t vd_i,

  // Pixel towards the output stage
  output logic          pixValid_o,
  output colorIn_t      red_o,
  output colorIn_t      green_o,
  output colorIn_t      blue_o,
  output syncBits_t     pixSync_o
);

  demuxState_t state;
  syncBits_t   syncCap;
  colorIn_t    redCap;
  colorIn_t    greenCap;
  logic        blueNow;

  // Blue word is on the bus right after green
  // A sync word here cancels the group
  assign blueNow = nVDSYNC_i & (state == GREEN);

  ////////////////////
  // Phase tracking
  ////////////////////

  always_ff @(posedge VCLK or negedge rstN_i) begin
    if (!rstN_i) begin
      // Idle until the first sync word
      state      <= BLUE;
      pixValid_o <= 1'b0;
    end else begin
      pixValid_o <= blueNow;
      if (!nVDSYNC_i) begin
        // Sync word always restarts the group
        state <= SYNC;
      end else begin
        case (state)
          SYNC:    state <= RED;
          RED:     state <= GREEN;
          GREEN:   state <= BLUE;
          // Group complete, wait for next sync
          default: state <= BLUE;
        endcase
      end
    end
  end

  ////////////////////
  // Word capture
  ////////////////////

  always_ff @(posedge VCLK) begin
    if (!nVDSYNC_i) begin
      syncCap <= vd_i[`SYNC_VS:`SYNC_CS];
    end else begin
      case (state)
        SYNC:    redCap   <= vd_i;
        RED:     greenCap <= vd_i;
        default: ;
      endcase
    end
  end

  // Whole pixel handed over with blue
  // Capture registers are free again for the next group
  always_ff @(posedge VCLK) begin
    if (blueNow) begin
      red_o     <= redCap;
      green_o   <= greenCap;
      blue_o    <= vd_i;
      pixSync_o <= syncCap;
    end
  end

endmodule

`default_nettype wire

/* verilog/n64adv_cfgRegs.sv */
// Wishbone classic register block that overrides the jumper settings and reports the line count
`timescale 1ns/1ps
`default_nettype none

`include "n64adv_defs.svh"

module n64adv_cfgRegs
  import n64adv_pkg::*;
(
  input  wire          VCLK,
  input  wire          rstN_i,

  // Wishbone classic slave
  input  wire          wbCyc_i,
  input  wire          wbStb_i,
  input  wire          wbWe_i,
  input  wire          wbAdr_i,
  input  wire wbData_t wbDat_i,
  output wbData_t      wbDat_o,
  output logic         wbAck_o,

  // Jumper pins
  input  wire          useVgaHVSyncJmp_i,
  input  wire          nEnRGsBJmp_i,
  input  wire slStr_t  slStrJmpN_i,

  // Status from the output stage
  input  wire lineCnt_t lastLineCnt_i,

  // Effective settings
  output logic         useVgaSync_o,
  output logic         enRGsB_o,
  output slStr_t       slStr_o
);

  // Bit positions in the configuration register
  localparam int CfgOvr   = 0;
  localparam int CfgVga   = 1;
  localparam int CfgRGsB  = 2;
  localparam int CfgSlLsb = 3;
  localparam int CfgSlMsb = 4;

  logic [CfgSlMsb:0] cfgReg;
  logic              wbReq;
  logic              selCfg;
  logic              selStat;

  // New request only while no ack is pending
  assign wbReq   = wbCyc_i & wbStb_i & ~wbAck_o;
  assign selCfg  = (wbAdr_i == 1'(`ADDR_CFG));
  assign selStat = (wbAdr_i == 1'(`ADDR_STAT));

  ////////////////////
  // Bus handshake
  ////////////////////

  always_ff @(posedge VCLK or negedge rstN_i) begin
    if (!rstN_i) begin
      wbAck_o <= 1'b0;
      cfgReg  <= '0;
    end else begin
      // One wait state, ack lasts a single cycle
      wbAck_o <= wbReq;
      // Register is written as ack rises
      // Status address is read only
      if (wbReq && wbWe_i && selCfg) begin
        cfgReg <= wbDat_i[CfgSlMsb:0];
      end
    end
  end

  // Read data is held through the ack cycle
  always_ff @(posedge VCLK) begin
    if (wbReq) begin
      if (selStat) begin
        wbDat_o <= lastLineCnt_i[7:0];
      end else begin
        wbDat_o <= {3'b000, cfgReg};
      end
    end
  end

  ////////////////////
  // Setting select
  ////////////////////

  always_comb begin
    if (cfgReg[CfgOvr]) begin
      useVgaSync_o = cfgReg[CfgVga];
      enRGsB_o     = cfgReg[CfgRGsB];
      slStr_o      = cfgReg[CfgSlMsb:CfgSlLsb];
    end else begin
      // Jumpers, inverted where they are active low
      useVgaSync_o = useVgaHVSyncJmp_i;
      enRGsB_o     = ~nEnRGsBJmp_i;
      slStr_o      = ~slStrJmpN_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/n64adv_pkg.sv */
// Design types shared by the video path modules, imported by wildcard where needed
`default_nettype none

`include "n64adv_defs.svh"

package n64adv_pkg;

  ////////////////////
  // Vector types
  ////////////////////

  // Console colour word
  typedef logic [`COLOR_W_I-1:0] colorIn_t;
  // Widened colour word towards the DAC
  typedef logic [`COLOR_W_O-1:0] colorOut_t;
  // Sync group {vsync, clamp, hsync, csync}, active low
  typedef logic [3:0] syncBits_t;
  // Scanline strength, 0 means off
  typedef logic [1:0] slStr_t;
  // Line counter of one frame
  typedef logic [`LINECNT_W-1:0] lineCnt_t;
  // Wishbone data word
  typedef logic [7:0] wbData_t;

  ////////////////////
  // State machines
  ////////////////////

  // Demux phase, names the word captured last
  typedef enum logic [1:0] {
    SYNC,
    RED,
    GREEN,
    BLUE
  } demuxState_t;

endpackage

`default_nettype wire

/* verilog/n64adv_defs.svh */
// Shared widths, register addresses and sync bit positions, included by the RTL and testbench
`ifndef N64ADV_DEFS_SVH
`define N64ADV_DEFS_SVH

////////////////////
// Video bus widths
////////////////////

// Colour word as sent by the console
`define COLOR_W_I 7
// Colour word as taken by the DAC
`define COLOR_W_O 8
// Lines per frame fit easily in 10 bits
`define LINECNT_W 10

// Wishbone register map
`define ADDR_CFG  0
`define ADDR_STAT 1

// Bit positions within the sync word (all active low)
`define SYNC_VS    3
`define SYNC_CLAMP 2
`define SYNC_HS    1
`define SYNC_CS    0

`endif
